//--- project.f
src/prom_pkg.sv
src/prom_if.sv
src/prom_cmd_decode.sv
src/prom_blk_buffer.sv
src/prom_spi_engine.sv
src/prom_result_collect.sv
src/prom_ctrl_top.sv
dv/tb_clock.sv
dv/spi_flash_model.sv
dv/prom_assert.sv
dv/prom_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the PROM engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module prom_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vprom_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
exit 1

//--- dv/prom_tb.sv
// Top testbench of the SPI PROM command engine
// Random single commands and block programs against a reference model
// Checks results, done latency, flash byte log, credits and status word
`timescale 1ns/1ps
`default_nettype none

module prom_tb import prom_pkg::*; ();

    logic        clk;
    logic        reset;
    logic        cmd_wen;
    logic [31:0] cmd;
    logic        blk_start;
    logic        blk_wen;
    logic [5:0]  blk_addr;
    logic        blk_end;
    logic        credit_ret;
    logic [31:0] result;
    logic        done;
    logic [31:0] status;
    logic        prom_mosi;
    logic        prom_miso;
    logic        prom_sclk;
    logic        prom_cs;

    int          seed = 32'h9d7;
    int          errors = 0;
    int          timeouts = 0;
    logic [7:0]  status_model = 8'h00;  // Last byte written by Write Status

    tb_clock clock_gen (.clk(clk), .reset(reset));

    prom_ctrl_top uut (
        .clk(clk), .reset(reset), .cmd_wen(cmd_wen), .cmd(cmd),
        .blk_start(blk_start), .blk_wen(blk_wen), .blk_addr(blk_addr),
        .blk_end(blk_end), .credit_ret(credit_ret), .result(result),
        .done(done), .status(status), .prom_mosi(prom_mosi),
        .prom_miso(prom_miso), .prom_sclk(prom_sclk), .prom_cs(prom_cs)
    );

    spi_flash_model flash (.sclk(prom_sclk), .cs(prom_cs), .mosi(prom_mosi), .miso(prom_miso));

    task automatic check32(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Status word mirrors the SPI pins, busy while chip select is low
    task automatic check_status();
        check32("status pins",
                {28'h0, status[stat_cs], status[stat_sclk], status[stat_miso], status[stat_mosi]},
                {28'h0, prom_cs, prom_sclk, prom_miso, prom_mosi});
        if (!prom_cs) check32("status busy", {31'h0, status[stat_busy]}, 32'h1);
    endtask

    // Bytes sent per opcode, fast read dummy included
    function automatic int send_bytes(input logic [7:0] op);
        case (op)
            op_wrsr:                      return 2;
            op_read, op_se, op_res:       return 4;
            op_fast_read:                 return 5;
            default:                      return 1;
        endcase
    endfunction

    function automatic int recv_bits(input logic [7:0] op);
        case (op)
            op_rdid:                      return 24;
            op_rdsr, op_res:              return 8;
            op_read, op_fast_read:        return 32;
            default:                      return 0;
        endcase
    endfunction

    function automatic logic [7:0] flash_byte(input logic [23:0] a);
        return a[7:0] ^ 8'h5A;
    endfunction

    function automatic logic [31:0] expect_result(input logic [31:0] c);
        case (c[31:24])
            op_rdid:               return 32'h00202015;
            op_rdsr:               return {24'h0, status_model};
            op_read, op_fast_read: return {flash_byte(c[23:0]), flash_byte(c[23:0] + 24'd1),
                                          flash_byte(c[23:0] + 24'd2), flash_byte(c[23:0] + 24'd3)};
            op_res:                return 32'h00000014;
            default:               return 32'h0;  // No receive phase
        endcase
    endfunction

    function automatic logic [7:0] pick_op(input int i);
        case (i)
            0: return op_wren;
            1: return op_wrdi;
            2: return op_rdid;
            3: return op_rdsr;
            4: return op_wrsr;
            5: return op_read;
            6: return op_fast_read;
            7: return op_se;
            8: return op_be;
            9: return op_dp;
            default: return op_res;
        endcase
    endfunction

    task automatic run_cmd(input logic [31:0] c);
        int          sb;
        int          rb;
        int          cycles;
        int          k;
        bit          got_done;
        logic [31:0] exp;
        sb = send_bytes(c[31:24]);
        rb = recv_bits(c[31:24]);
        exp = expect_result(c);
        got_done = 0;
        cycles = 0;
        @(negedge clk);
        cmd_wen = 1'b1;
        cmd = c;
        while (!got_done && cycles < 500) begin
            @(negedge clk);
            cmd_wen = 1'b0;
            cycles++;
            check_status();
            if (done) got_done = 1;
        end
        if (!got_done) begin
            $display("Timeout: no done after command %h", c);
            timeouts++;
        end else begin
            check32("result", result, exp);
            // Counted from the edge that takes cmd_wen, plus the sampling half cycle
            check32("done latency", cycles, 16 * sb + 2 * rb + 5);
            check32("status at done", status & 32'h0000_01CF, 32'h0000_0080);  // Idle, cs high
            check32("flash byte count", flash.log_cnt, sb);
            for (k = 0; k < sb && k < flash.log_cnt; k++) begin
                check32("flash byte", {24'h0, flash.log_mem[k]},
                        (k < 4) ? {24'h0, c[31 - 8 * k -: 8]} : 32'h0);
            end
        end
        if (c[31:24] == op_wrsr) status_model = c[23:16];
    endtask

    task automatic run_block(input int n, input bit bad_addr);
        logic [31:0] data [64];
        logic [31:0] hdr;
        logic [31:0] r;
        logic [31:0] exp_byte;
        int          written;
        int          returned;
        int          credits;
        int          cycles;
        int          exp_cnt;
        int          k;
        bit          end_sent;
        bit          got_done;
        bit          saw_blk;
        for (k = 0; k < n; k++) data[k] = $random(seed);
        r = $random(seed);
        hdr = {op_pp, r[23:0]};
        written = 0;
        returned = 0;
        credits = blk_depth;        // Host starts each block with full credit
        cycles = 0;
        end_sent = 0;
        got_done = 0;
        saw_blk = 0;
        @(negedge clk);
        blk_start = 1'b1;
        cmd = hdr;
        @(negedge clk);
        blk_start = 1'b0;
        while (!got_done && cycles < 20000) begin
            @(negedge clk);
            cycles++;
            blk_wen = 1'b0;
            blk_end = 1'b0;
            if (credit_ret) begin
                returned++;
                credits++;
            end
            assert (returned <= written) else begin
                $display("Credit returned for a quadlet the host never wrote");
                errors++;
            end
            check_status();
            if (status[stat_blk]) saw_blk = 1;
            if (done) begin
                got_done = 1;
            end else if (written < n) begin
                r = $random(seed);
                if (credits > 0 && r[1:0] != 2'b00) begin   // Random host gaps
                    blk_wen = 1'b1;
                    blk_addr = (bad_addr && written == 1) ? 6'd9 : 6'(written);
                    cmd = data[written];
                    credits--;
                    written++;
                end
            end else if (!end_sent) begin
                blk_end = 1'b1;
                end_sent = 1;
            end
        end
        if (!got_done) begin
            $display("Timeout: block program of %0d quadlets never finished", n);
            timeouts++;
        end else begin
            exp_cnt = bad_addr ? 1 : n;     // Writes after a bad address all miss
            check32("result", result, {bad_addr, 24'h0, 7'(exp_cnt)});
            check32("status at done", status & 32'h0000_01CF, 32'h0000_0080);
            check32("status blk seen", {31'h0, saw_blk}, 32'h1);
            if (!bad_addr) begin
                check32("credit_ret count", returned, n);
                check32("flash byte count", flash.log_cnt, 4 + 4 * n);
                for (k = 0; k < 4 + 4 * n && k < flash.log_cnt && k < 256; k++) begin
                    if (k < 4) exp_byte = {24'h0, hdr[31 - 8 * k -: 8]};
                    else exp_byte = {24'h0, data[(k - 4) / 4][31 - 8 * ((k - 4) % 4) -: 8]};
                    check32("flash byte", {24'h0, flash.log_mem[k]}, exp_byte);
                end
            end
        end
    endtask

    initial begin
        int          i;
        int          wait_cnt;
        logic [31:0] r;
        cmd_wen = 1'b0;
        cmd = 32'h0;
        blk_start = 1'b0;
        blk_wen = 1'b0;
        blk_addr = 6'h0;
        blk_end = 1'b0;
        wait_cnt = 0;
        while (!reset && wait_cnt < 20) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!reset) begin
            $display("Reset never released");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            run_cmd({op_wrsr, 8'hA5, 16'h0});   // Status write then read back
            run_cmd({op_rdsr, 24'h0});
            run_cmd({op_rdid, 24'h0});
            for (i = 0; i < 60; i++) begin
                r = $random(seed);
                run_cmd({pick_op({r[31:8]} % 11), r[23:0]});
            end
            run_block(1, 1'b0);
            for (i = 0; i < 3; i++) begin
                r = $random(seed);
                run_block(1 + ({r[30:0]} % 40), 1'b0);
            end
            run_block(40, 1'b0);
            run_block(3, 1'b1);
            $display("Errors: %0d check failures, %0d timeouts", errors, timeouts);
            if (errors == 0 && timeouts == 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- dv/prom_assert.sv
// SPI protocol assertions for the PROM engine
// Chip select in idle, sclk gating, MOSI stability, frame handshake
`timescale 1ns/1ps
`default_nettype none

module prom_assert import prom_pkg::*; (
    input logic       clk,
    input logic       reset,
    input eng_state_t state,
    input logic       prom_cs,
    input logic       prom_sclk,
    input logic       prom_mosi,
    input logic       frame_valid,
    input logic       frame_busy
);

    cs_idle: assert property (@(posedge clk) disable iff (!reset)
        (state == st_idle) |-> prom_cs)
        else $error("prom_cs low while engine idle");

    sclk_gated: assert property (@(posedge clk) disable iff (!reset)
        $changed(prom_sclk) |-> !prom_cs)
        else $error("prom_sclk toggled with prom_cs high");

    mosi_stable: assert property (@(posedge clk) disable iff (!reset)
        $rose(prom_sclk) |-> $stable(prom_mosi))
        else $error("prom_mosi changed at rising prom_sclk");

    frame_handshake: assert property (@(posedge clk) disable iff (!reset)
        frame_valid |-> !frame_busy)
        else $error("frame_valid raised while engine busy");

endmodule

bind prom_spi_engine prom_assert u_assert (
    .clk         (clk),
    .reset       (reset),
    .state       (state),
    .prom_cs     (prom_cs),
    .prom_sclk   (prom_sclk),
    .prom_mosi   (prom_mosi),
    .frame_valid (frame.frame_valid),
    .frame_busy  (frame.frame_busy)
);

`default_nettype wire

//--- dv/spi_flash_model.sv
// Behavioral SPI NOR flash
// Logs command bytes, answers ID, status, read and release
// Data at address a is the low byte of a XOR 5A
`timescale 1ns/1ps
`default_nettype none

module spi_flash_model (
    input  wire  sclk,
    input  wire  cs,
    input  wire  mosi,
    output logic miso
);

    logic [7:0]  log_mem [256];     // Bytes seen in the current frame
    int          log_cnt;
    int          bit_cnt;
    logic [7:0]  sh;
    logic [7:0]  opcode;
    logic [23:0] addr;
    logic [7:0]  status_reg;
    logic [31:0] resp;              // Left-aligned answer
    logic        resp_on;

    function automatic logic [7:0] mem_byte(input logic [23:0] a);
        return a[7:0] ^ 8'h5A;
    endfunction

    initial begin
        miso       = 1'b0;
        status_reg = 8'h00;
        resp_on    = 1'b0;
        log_cnt    = 0;
        bit_cnt    = 0;
    end

    // New frame on falling chip select
    always @(negedge cs) begin
        log_cnt = 0;
        bit_cnt = 0;
        resp_on = 1'b0;
    end

    // Capture MOSI on rising sclk until the answer starts
    always @(posedge sclk) begin
        if (!cs && !resp_on) begin
            sh = {sh[6:0], mosi};
            bit_cnt++;
            if (bit_cnt % 8 == 0) begin
                if (log_cnt < 256) log_mem[log_cnt] = sh;
                log_cnt++;
                if (log_cnt == 1) opcode = sh;
                if (log_cnt >= 2 && log_cnt <= 4) addr = {addr[15:0], sh};
                case (opcode)
                    8'h9F: if (log_cnt == 1) begin
                        resp = 32'h20201500;
                        resp_on = 1'b1;
                    end
                    8'h05: if (log_cnt == 1) begin
                        resp = {status_reg, 24'h0};
                        resp_on = 1'b1;
                    end
                    8'h01: if (log_cnt == 2) status_reg = sh;
                    8'h03, 8'h0B: if (log_cnt == ((opcode == 8'h03) ? 4 : 5)) begin
                        resp = {mem_byte(addr), mem_byte(addr + 24'd1),
                                mem_byte(addr + 24'd2), mem_byte(addr + 24'd3)};
                        resp_on = 1'b1;
                    end
                    8'hAB: if (log_cnt == 4) begin
                        resp = 32'h14000000;
                        resp_on = 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Answer bits change on falling sclk
    always @(negedge sclk) begin
        if (!cs && resp_on) begin
            miso <= resp[31];
            resp = resp << 1;
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
// Testbench clock and reset source
// 4 ns clock, active-low reset held for 3 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;      // 4 ns period
    end

    initial begin
        reset = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;               // Released away from the sampling edge
    end

endmodule

`default_nettype wire

//--- src/prom_ctrl_top.sv
// Top level of the SPI PROM command engine
// Connects decode, block buffer, SPI engine and result stage
// and packs the status word
`timescale 1ns/1ps
`default_nettype none

module prom_ctrl_top import prom_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        cmd_wen,
    input  logic [31:0] cmd,        // Command, also block data
    input  logic        blk_start,
    input  logic        blk_wen,
    input  logic [5:0]  blk_addr,
    input  logic        blk_end,
    output logic        credit_ret,
    output logic [31:0] result,
    output logic        done,
    output logic [31:0] status,
    output logic        prom_mosi,
    input  logic        prom_miso,
    output logic        prom_sclk,
    output logic        prom_cs
);

    spi_frame_if frame_bus ();
    spi_rx_if    rx_bus ();

    logic        buf_avail;
    logic [31:0] buf_data;
    logic        buf_pop;
    logic        buf_last;
    logic        blk_err;
    eng_state_t  eng_state;

    prom_cmd_decode u_decode (
        .clk       (clk),
        .reset     (reset),
        .cmd_wen   (cmd_wen),
        .cmd       (cmd),
        .blk_start (blk_start),
        .frame     (frame_bus.decode)
    );

    prom_blk_buffer u_buffer (
        .clk        (clk),
        .reset      (reset),
        .blk_start  (blk_start),
        .blk_wen    (blk_wen),
        .blk_end    (blk_end),
        .blk_addr   (blk_addr),
        .wdata      (cmd),
        .buf_avail  (buf_avail),
        .buf_data   (buf_data),
        .buf_pop    (buf_pop),
        .buf_last   (buf_last),
        .credit_ret (credit_ret),
        .blk_err    (blk_err)
    );

    prom_spi_engine u_engine (
        .clk       (clk),
        .reset     (reset),
        .frame     (frame_bus.engine),
        .buf_avail (buf_avail),
        .buf_data  (buf_data),
        .buf_last  (buf_last),
        .buf_pop   (buf_pop),
        .rx        (rx_bus.engine),
        .prom_mosi (prom_mosi),
        .prom_sclk (prom_sclk),
        .prom_cs   (prom_cs),
        .prom_miso (prom_miso),
        .state     (eng_state)
    );

    prom_result_collect u_result (
        .clk     (clk),
        .reset   (reset),
        .rx      (rx_bus.result),
        .blk_err (blk_err),
        .result  (result),
        .done    (done)
    );

    // Live pin and state view for the host
    always_comb begin
        status                                = '0;
        status[stat_state_msb:stat_state_lsb] = eng_state;
        status[stat_blk]                      = (eng_state == st_block);
        status[stat_mosi]                     = prom_mosi;
        status[stat_miso]                     = prom_miso;
        status[stat_sclk]                     = prom_sclk;
        status[stat_cs]                       = prom_cs;
        status[stat_busy]                     = (eng_state != st_idle);
    end

endmodule

`default_nettype wire

//--- src/prom_result_collect.sv
// Result stage of the PROM engine
// Shifts received bits into the result word, reports the
// block quadlet count with the error flag, and raises done
`timescale 1ns/1ps
`default_nettype none

module prom_result_collect import prom_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    spi_rx_if.result    rx,
    input  logic        blk_err,
    output logic [31:0] result,
    output logic        done
);

    logic blk_frame;  // Frame streamed at least one buffer quadlet

    assign blk_frame = (rx.blk_count != '0);

    always_ff @(posedge clk) begin
        if (!reset) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= rx.rx_done;                         // One cycle, release lasts one
            if (rx.rx_clear) begin
                result <= '0;                           // Right-aligned accumulation
            end else if (rx.rx_strobe) begin
                result <= {result[30:0], rx.rx_bit};
            end else if (rx.rx_done && blk_frame) begin
                // Block program reports quadlets written, error in the top bit
                result <= {blk_err, {(31 - cnt_w){1'b0}}, rx.blk_count};
            end
        end
    end

endmodule

`default_nettype wire

//--- src/prom_spi_engine.sv
// SPI engine for the serial PROM
// Chip select sequencing, sclk from the sequence counter,
// MOSI shifting, block streaming from the buffer, MISO sampling
`timescale 1ns/1ps
`default_nettype none

module prom_spi_engine import prom_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    spi_frame_if.engine frame,
    input  logic        buf_avail,
    input  logic [31:0] buf_data,
    input  logic        buf_last,
    output logic        buf_pop,
    spi_rx_if.engine    rx,
    output logic        prom_mosi,
    output logic        prom_sclk,
    output logic        prom_cs,
    input  logic        prom_miso,
    output eng_state_t  state
);

    logic [cnt_w-1:0] seqn;        // Bit 0 is sclk
    logic [cnt_w-1:0] send_cnt;
    logic [cnt_w-1:0] recv_cnt;
    logic [31:0]      shift_q;     // MSB drives MOSI
    logic             blk_mode;
    logic             blk_loaded;  // Current quadlet taken from buffer
    logic [cnt_w-1:0] blk_count;

    assign prom_sclk        = seqn[0];
    assign prom_mosi        = shift_q[31];
    assign frame.frame_busy = (state != st_idle);

    // Pop only at a quadlet boundary with sclk low
    assign buf_pop = (state == st_block) && !blk_loaded && buf_avail;

    // Result side sees one strobe per low sclk phase in recv
    assign rx.rx_clear  = (state == st_select);
    assign rx.rx_bit    = prom_miso;
    assign rx.rx_strobe = (state == st_recv) && !seqn[0];
    assign rx.rx_done   = (state == st_release);
    assign rx.blk_count = blk_count;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state      <= st_idle;
            seqn       <= '0;
            prom_cs    <= 1'b1;
            shift_q    <= '0;
            blk_mode   <= 1'b0;
            blk_loaded <= 1'b0;
            blk_count  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (frame.frame_valid) begin
                        shift_q   <= frame.frame_data;
                        send_cnt  <= frame.send_cnt;
                        recv_cnt  <= frame.recv_cnt;
                        blk_mode  <= frame.frame_block;
                        blk_count <= '0;
                        seqn      <= '0;
                        state     <= st_select;
                    end
                end
                st_select: begin
                    prom_cs <= 1'b0;                    // Chip select falls with sclk low
                    state   <= st_send;
                end
                st_send: begin
                    if (prom_sclk) shift_q <= shift_q << 1;  // Next bit at falling sclk
                    if (seqn == send_cnt) begin
                        seqn       <= '0;
                        blk_loaded <= 1'b0;
                        if (blk_mode) state <= st_block;
                        else if (recv_cnt == '0) state <= st_deselect;
                        else state <= st_recv;
                    end else begin
                        seqn <= seqn + 1'b1;
                    end
                end
                st_block: begin
                    if (!blk_loaded) begin
                        if (buf_avail) begin
                            shift_q    <= buf_data;
                            blk_loaded <= 1'b1;
                            blk_count  <= blk_count + 1'b1;
                        end else if (buf_last) begin
                            state <= st_deselect;   // Host finished and buffer drained
                        end
                        // Otherwise stall here with sclk low
                    end else begin
                        if (prom_sclk) shift_q <= shift_q << 1;
                        if (seqn == quad_cnt) begin
                            seqn       <= '0;
                            blk_loaded <= 1'b0;
                        end else begin
                            seqn <= seqn + 1'b1;
                        end
                    end
                end
                st_recv: begin
                    seqn <= seqn + 1'b1;            // Ends on an even count, sclk low
                    if (seqn == recv_cnt) state <= st_deselect;
                end
                st_deselect: begin
                    prom_cs <= 1'b1;
                    state   <= st_release;
                end
                st_release: begin
                    seqn  <= '0;
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/prom_blk_buffer.sv
// Block write buffer between host and SPI engine
// Circular quadlet store with host address check,
// credit return on each pop and end-of-block tracking
`timescale 1ns/1ps
`default_nettype none

module prom_blk_buffer import prom_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        blk_start,
    input  logic        blk_wen,
    input  logic        blk_end,
    input  logic [5:0]  blk_addr,
    input  logic [31:0] wdata,
    output logic        buf_avail,
    output logic [31:0] buf_data,
    input  logic        buf_pop,
    output logic        buf_last,
    output logic        credit_ret,
    output logic        blk_err
);

    logic [31:0]          mem [blk_depth];
    logic [5:0]           wr_seq;     // Expected host address
    logic [blk_idx_w-1:0] rd_idx;
    logic [blk_idx_w:0]   fill;       // Entries held
    logic                 blk_open;   // Between blk_start and blk_end
    logic                 wr_ok;

    // Full buffer means the host wrote without a credit
    assign wr_ok     = blk_wen && blk_open && (blk_addr == wr_seq)
                       && (fill != (blk_idx_w + 1)'(blk_depth));
    assign buf_avail = (fill != '0);
    assign buf_data  = mem[rd_idx];                 // Head, valid with buf_avail

    always_ff @(posedge clk) begin
        if (wr_ok) mem[wr_seq[blk_idx_w-1:0]] <= wdata;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_seq     <= '0;
            rd_idx     <= '0;
            fill       <= '0;
            blk_open   <= 1'b0;
            buf_last   <= 1'b0;
            blk_err    <= 1'b0;
            credit_ret <= 1'b0;
        end else begin
            credit_ret <= buf_pop;                  // One credit per consumed quadlet
            if (blk_start) begin
                wr_seq   <= '0;
                rd_idx   <= '0;
                fill     <= '0;
                blk_open <= 1'b1;
                buf_last <= 1'b0;
                blk_err  <= 1'b0;
            end else begin
                if (wr_ok) wr_seq <= wr_seq + 1'b1;
                else if (blk_wen) blk_err <= 1'b1;  // Sticky until next block
                if (buf_pop) rd_idx <= rd_idx + 1'b1;
                case ({wr_ok, buf_pop})
                    2'b10:   fill <= fill + 1'b1;
                    2'b01:   fill <= fill - 1'b1;
                    default: fill <= fill;
                endcase
                if (blk_end && blk_open) begin
                    blk_open <= 1'b0;
                    buf_last <= 1'b1;               // Empty now means frame done
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/prom_cmd_decode.sv
// Command decode for the PROM engine
// Maps the opcode of a host quadlet to send and receive counts
// and issues single or block frames to the SPI engine
`timescale 1ns/1ps
`default_nettype none

module prom_cmd_decode import prom_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        cmd_wen,
    input  logic [31:0] cmd,
    input  logic        blk_start,
    spi_frame_if.decode frame
);

    logic [cnt_w-1:0] snd_lut;   // Send count for this opcode
    logic [cnt_w-1:0] rcv_lut;   // Receive count for this opcode
    logic             op_known;  // Opcode has a frame
    logic             can_issue;

    // Never stack a frame on a busy engine or a pending strobe
    assign can_issue = !frame.frame_busy && !frame.frame_valid;

    // Opcode table, one byte out unless stated
    always_comb begin
        snd_lut  = 7'd15;
        rcv_lut  = 7'd0;
        op_known = 1'b1;
        case (cmd[31:24])
            op_wren, op_wrdi, op_be, op_dp: begin
            end
            op_rdid: rcv_lut = 7'd47;       // 24-bit ID
            op_rdsr: rcv_lut = 7'd15;       // Status byte
            op_wrsr: snd_lut = 7'd31;       // Opcode plus status byte
            op_read: begin
                snd_lut = 7'd63;            // Opcode plus 24-bit address
                rcv_lut = 7'd63;
            end
            op_fast_read: begin
                snd_lut = 7'd79;            // Trailing dummy byte shifts out as zero
                rcv_lut = 7'd63;
            end
            op_se: snd_lut = 7'd63;
            op_res: begin
                snd_lut = 7'd63;            // Three dummy bytes
                rcv_lut = 7'd15;
            end
            default: op_known = 1'b0;       // No-op and unknown opcodes
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            frame.frame_valid <= 1'b0;
            frame.frame_block <= 1'b0;
        end else begin
            frame.frame_valid <= 1'b0;              // Single-cycle strobe
            if (can_issue) begin
                if (blk_start) begin
                    // First quadlet of page program is opcode plus address
                    frame.frame_valid <= 1'b1;
                    frame.frame_block <= 1'b1;
                    frame.frame_data  <= {op_pp, cmd[23:0]};
                    frame.send_cnt    <= quad_cnt;
                    frame.recv_cnt    <= '0;
                end else if (cmd_wen && op_known && (snd_lut < max_frame_bits)) begin
                    frame.frame_valid <= 1'b1;
                    frame.frame_block <= 1'b0;
                    frame.frame_data  <= cmd;
                    frame.send_cnt    <= snd_lut;
                    frame.recv_cnt    <= rcv_lut;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/prom_if.sv
// Internal buses of the PROM engine
// spi_frame_if carries one frame from decode to the SPI engine
// spi_rx_if carries received bits and block count to the result stage
`timescale 1ns/1ps
`default_nettype none

interface spi_frame_if import prom_pkg::*; ();
    logic             frame_valid;  // One-cycle issue strobe
    logic [31:0]      frame_data;   // Sent MSB first
    logic [cnt_w-1:0] send_cnt;     // 2*bits-1
    logic [cnt_w-1:0] recv_cnt;     // 2*bits-1, zero for none
    logic             frame_block;  // Page program with buffer streaming
    logic             frame_busy;   // Engine not idle

    modport decode (output frame_valid, frame_data, send_cnt, recv_cnt, frame_block,
                    input  frame_busy);
    modport engine (input  frame_valid, frame_data, send_cnt, recv_cnt, frame_block,
                    output frame_busy);
endinterface

interface spi_rx_if import prom_pkg::*; ();
    logic             rx_clear;   // Frame start
    logic             rx_bit;     // Sampled MISO
    logic             rx_strobe;  // rx_bit valid
    logic             rx_done;    // Frame finished
    logic [cnt_w-1:0] blk_count;  // Quadlets streamed from buffer

    modport engine (output rx_clear, rx_bit, rx_strobe, rx_done, blk_count);
    modport result (input  rx_clear, rx_bit, rx_strobe, rx_done, blk_count);
endinterface

`default_nettype wire

//--- src/prom_pkg.sv
// Shared definitions for the SPI PROM command engine
// SPI opcodes, frame counter limits, block buffer sizing,
// engine state encoding and status word bit positions
`default_nettype none

package prom_pkg;

    // Flash opcodes
    localparam logic [7:0] op_wren       = 8'h06;  // Write enable
    localparam logic [7:0] op_wrdi       = 8'h04;  // Write disable
    localparam logic [7:0] op_rdid       = 8'h9F;  // Read ID, 3 bytes back
    localparam logic [7:0] op_rdsr       = 8'h05;  // Read status
    localparam logic [7:0] op_wrsr       = 8'h01;  // Write status
    localparam logic [7:0] op_read       = 8'h03;  // Read data
    localparam logic [7:0] op_fast_read  = 8'h0B;  // Read data plus dummy byte
    localparam logic [7:0] op_se         = 8'hD8;  // Sector erase
    localparam logic [7:0] op_be         = 8'hC7;  // Bulk erase
    localparam logic [7:0] op_dp         = 8'hB9;  // Deep power down
    localparam logic [7:0] op_res        = 8'hAB;  // Release, old style ID
    localparam logic [7:0] op_pp         = 8'h02;  // Page program, block only

    // Half-clock counters, value is 2*bits-1
    localparam int                 cnt_w          = 7;
    localparam logic [cnt_w-1:0]   max_frame_bits = 7'd98;  // Upper bound on send count
    localparam logic [cnt_w-1:0]   quad_cnt       = 7'd63;  // One 32-bit quadlet

    // Block buffer
    localparam int blk_depth = 16;  // Quadlets, also host credits
    localparam int blk_idx_w = 4;

    typedef enum logic [2:0] {
        st_idle,
        st_select,
        st_send,
        st_block,
        st_recv,
        st_deselect,
        st_release
    } eng_state_t;

    // Status word layout
    localparam int stat_state_lsb = 0;
    localparam int stat_state_msb = 2;
    localparam int stat_blk       = 3;
    localparam int stat_mosi      = 4;
    localparam int stat_miso      = 5;
    localparam int stat_sclk      = 6;
    localparam int stat_cs        = 7;
    localparam int stat_busy      = 8;

endpackage

`default_nettype wire
